// ==== verilog.f ====
rtl/mem_pkg.sv
rtl/cmd_pkg.sv
rtl/ram_port_if.sv
rtl/stage_if.sv
rtl/store_ram.sv
rtl/stage_buffer.sv
rtl/sector_ctrl.sv
rtl/sector_bridge.sv
verif/tb_sector_bridge.sv

// ==== verif/tb_sector_bridge.sv ====
`timescale 1ns/1ns

module tb_sector_bridge;

	localparam int SECTOR_BITS    = 4;
	localparam int COUNT_BITS     = 3;
	localparam int WORDS          = 1 << SECTOR_BITS;
	localparam int ADDR_WIDTH     = SECTOR_BITS + COUNT_BITS;
	localparam int TIMEOUT_CYCLES = 400;

	// one row of the stimulus table
	typedef struct packed {
		cmd_pkg::op_t op;
		logic [7:0]   sector;
		logic         use_core;
		logic         stall;
		logic         exp_error;
	} test_t;

	logic                  clock;
	logic                  reset;
	logic                  in_valid;
	logic                  in_ready;
	mem_pkg::word_t        in_data;
	logic                  out_valid;
	logic                  out_ready;
	mem_pkg::word_t        out_data;
	logic                  busy;
	logic                  error;
	logic [ADDR_WIDTH-1:0] core_address;
	mem_pkg::word_t        core_data;
	logic                  core_wren;
	mem_pkg::word_t        core_q;

	// expected contents of the whole store
	mem_pkg::word_t model [0:(1 << ADDR_WIDTH)-1];
	test_t          tests [$];
	int             errors;
	int             checks;

	sector_bridge dut0 (
		.clock        (clock),
		.reset        (reset),
		.in_valid     (in_valid),
		.in_ready     (in_ready),
		.in_data      (in_data),
		.out_valid    (out_valid),
		.out_ready    (out_ready),
		.out_data     (out_data),
		.busy         (busy),
		.error        (error),
		.core_address (core_address),
		.core_data    (core_data),
		.core_wren    (core_wren),
		.core_q       (core_q)
	);

	always #10 clock = ~clock;

	task compare(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			$display("[FAIL] %0t ns: %s: got %0h, expected %0h", $time, what, got, exp);
			errors++;
		end
	endtask

	task report_timeout(input string what);
		$display("timeout: waited %0d cycles for %s without success", TIMEOUT_CYCLES, what);
		errors++;
	endtask

	task add_case(input cmd_pkg::op_t op, input int sector, input bit use_core,
			input bit stall, input bit exp_error);
		test_t t;
		t.op        = op;
		t.sector    = sector[7:0];
		t.use_core  = use_core;
		t.stall     = stall;
		t.exp_error = exp_error;
		tests.push_back(t);
	endtask

	function string op_label(input cmd_pkg::op_t op);
		case (op)
			cmd_pkg::OP_WRITE: return "write";
			cmd_pkg::OP_READ:  return "read";
			cmd_pkg::OP_NONE:  return "none";
			default:           return "rsvd";
		endcase
	endfunction

	// holds the word until in_ready and returns just after the transfer edge
	task send_word(input mem_pkg::word_t w);
		int n;
		n        = 0;
		in_valid = 1'b1;
		in_data  = w;
		while (!in_ready && n < TIMEOUT_CYCLES) begin
			@(posedge clock);
			#2;
			n++;
		end
		if (!in_ready) begin
			report_timeout("in_ready");
		end else begin
			@(posedge clock);
			#2;
		end
		in_valid = 1'b0;
	endtask

	task send_header(input cmd_pkg::op_t op, input logic [7:0] sector);
		cmd_pkg::hdr_word_t hdr;
		hdr.f.op     = op;
		hdr.f.rsvd   = '0;
		hdr.f.sector = sector;
		send_word(hdr.raw);
	endtask

	task wait_idle();
		int n;
		n = 0;
		while (busy && n < TIMEOUT_CYCLES) begin
			@(posedge clock);
			#2;
			n++;
		end
		if (busy) begin
			report_timeout("busy to fall");
		end
	endtask

	task write_payload(input int sector);
		mem_pkg::word_t w;
		for (int i = 0; i < WORDS; i++) begin
			w = mem_pkg::word_t'($urandom);
			model[sector*WORDS + i] = w;
			send_word(w);
		end
		compare(in_ready, 0, "in_ready during copy to store");
	endtask

	// one word per transfer with random out_ready when stalling
	task receive_sector(input int sector, input bit stall);
		int             got;
		int             n;
		bit             was_stalled;
		mem_pkg::word_t held;
		got         = 0;
		n           = 0;
		was_stalled = 0;
		while (got < WORDS && n < TIMEOUT_CYCLES) begin
			if (was_stalled) begin
				compare(out_valid, 1, "out_valid held under stall");
				compare(out_data, held, "out_data held under stall");
			end
			out_ready   = stall ? 1'($urandom % 2) : 1'b1;
			was_stalled = out_valid && !out_ready;
			held        = out_data;
			if (out_valid && out_ready) begin
				compare(out_data, model[sector*WORDS + got], "read word");
				got++;
			end
			@(posedge clock);
			#2;
			n++;
		end
		out_ready = 1'b0;
		if (got < WORDS) begin
			report_timeout("all output words");
		end
	endtask

	task core_write(input int addr, input mem_pkg::word_t d);
		core_address = ADDR_WIDTH'(addr);
		core_data    = d;
		core_wren    = 1'b1;
		model[addr]  = d;
		@(posedge clock);
		#2;
		core_wren = 1'b0;
	endtask

	// q is valid one cycle after the address
	task core_read(input int addr, output mem_pkg::word_t q);
		core_address = ADDR_WIDTH'(addr);
		core_wren    = 1'b0;
		@(posedge clock);
		#2;
		q = core_q;
	endtask

	task check_through_core(input int sector);
		mem_pkg::word_t q;
		for (int i = 0; i < WORDS; i++) begin
			core_read(sector*WORDS + i, q);
			compare(q, model[sector*WORDS + i], "core port read");
		end
	endtask

	initial begin
		int    first_err;
		test_t t;

		clock        = 1'b0;
		reset        = 1'b1;
		in_valid     = 1'b0;
		in_data      = '0;
		out_ready    = 1'b0;
		core_address = '0;
		core_data    = '0;
		core_wren    = 1'b0;
		errors       = 0;
		checks       = 0;
		void'($urandom(32'h8cf77bb4));

		// op, sector, use core, stall, expected error
		add_case(cmd_pkg::OP_WRITE, 0, 0, 0, 0);
		add_case(cmd_pkg::OP_READ,  0, 0, 0, 0);
		add_case(cmd_pkg::OP_WRITE, 3, 0, 0, 0);
		add_case(cmd_pkg::OP_WRITE, 5, 0, 0, 0);
		add_case(cmd_pkg::OP_WRITE, 7, 0, 0, 0);
		add_case(cmd_pkg::OP_READ,  3, 0, 0, 0);
		add_case(cmd_pkg::OP_READ,  5, 0, 0, 0);
		add_case(cmd_pkg::OP_READ,  7, 0, 0, 0);
		add_case(cmd_pkg::OP_WRITE, 1, 1, 0, 0);
		add_case(cmd_pkg::OP_READ,  1, 1, 0, 0);
		add_case(cmd_pkg::OP_NONE,  1, 0, 0, 1);
		add_case(cmd_pkg::OP_RSVD,  0, 0, 0, 1);
		add_case(cmd_pkg::OP_WRITE, 8, 0, 0, 1);
		add_case(cmd_pkg::OP_READ,  255, 0, 0, 1);
		add_case(cmd_pkg::OP_WRITE, 2, 0, 0, 0);
		add_case(cmd_pkg::OP_READ,  2, 0, 0, 0);
		add_case(cmd_pkg::OP_READ,  2, 0, 1, 0);
		add_case(cmd_pkg::OP_READ,  0, 0, 1, 0);

		repeat (5) @(posedge clock);
		#2;
		reset = 1'b0;

		// idle state straight after reset
		first_err = errors;
		compare(in_ready, 1, "in_ready after reset");
		compare(out_valid, 0, "out_valid after reset");
		compare(busy, 0, "busy after reset");
		compare(error, 0, "error after reset");
		$display("case reset: %s", (errors == first_err) ? "ok" : "FAILED");

		for (int i = 0; i < tests.size(); i++) begin
			t         = tests[i];
			first_err = errors;
			if (t.op == cmd_pkg::OP_READ && t.use_core) begin
				for (int k = 0; k < WORDS; k += 5) begin
					core_write(int'(t.sector)*WORDS + k, mem_pkg::word_t'($urandom));
				end
			end
			send_header(t.op, t.sector);
			compare(error, t.exp_error, "error after header");
			if (t.exp_error) begin
				@(posedge clock);
				#2;
				compare(error, 0, "error is a single pulse");
				compare(in_ready, 1, "in_ready after rejected header");
				compare(out_valid, 0, "no output after rejected header");
				compare(busy, 0, "busy after rejected header");
			end else if (t.op == cmd_pkg::OP_WRITE) begin
				compare(busy, 1, "busy after write header");
				write_payload(t.sector);
				wait_idle();
				if (t.use_core) begin
					check_through_core(t.sector);
				end
			end else begin
				compare(busy, 1, "busy after read header");
				receive_sector(t.sector, t.stall);
				wait_idle();
				compare(out_valid, 0, "out_valid after read");
			end
			$display("case %0d: %s sector %0d: %s", i, op_label(t.op), t.sector,
				(errors == first_err) ? "ok" : "FAILED");
		end

		$display("%0d cases, %0d checks, %0d errors", tests.size() + 1, checks, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// ==== rtl/sector_bridge.sv ====
`timescale 1ns/1ns

module sector_bridge #(
	parameter int SECTOR_BITS = 4,
	parameter int COUNT_BITS  = 3
) (
	input  logic                              clock,
	input  logic                              reset,

	input  logic                              in_valid,
	output logic                              in_ready,
	input  mem_pkg::word_t                    in_data,

	output logic                              out_valid,
	input  logic                              out_ready,
	output mem_pkg::word_t                    out_data,

	output logic                              busy,
	output logic                              error,

	// emulated core side of the store
	input  logic [SECTOR_BITS+COUNT_BITS-1:0] core_address,
	input  mem_pkg::word_t                    core_data,
	input  logic                              core_wren,
	output mem_pkg::word_t                    core_q
);

	localparam int ADDR_WIDTH = SECTOR_BITS + COUNT_BITS;

	ram_port_if #(.ADDR_WIDTH(ADDR_WIDTH)) host_port ();
	ram_port_if #(.ADDR_WIDTH(ADDR_WIDTH)) core_port ();
	stage_if stage_bus ();

	assign core_port.address = core_address;
	assign core_port.data    = core_data;
	assign core_port.wren    = core_wren;
	assign core_q            = core_port.q;

	sector_ctrl #(
		.SECTOR_BITS (SECTOR_BITS),
		.COUNT_BITS  (COUNT_BITS)
	) ctrl0 (
		.clock     (clock),
		.reset     (reset),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_data   (in_data),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data),
		.busy      (busy),
		.error     (error),
		.store     (host_port.master),
		.stage     (stage_bus.controller)
	);

	stage_buffer #(
		.SECTOR_BITS (SECTOR_BITS)
	) stage0 (
		.clock (clock),
		.reset (reset),
		.stage (stage_bus.buffer)
	);

	// host on port a, core on port b
	store_ram #(
		.ADDR_WIDTH (ADDR_WIDTH)
	) store0 (
		.clock  (clock),
		.port_a (host_port.memory),
		.port_b (core_port.memory)
	);

endmodule

// ==== rtl/sector_ctrl.sv ====
`timescale 1ns/1ns

module sector_ctrl #(
	parameter int SECTOR_BITS = 4,
	parameter int COUNT_BITS  = 3
) (
	input  logic           clock,
	input  logic           reset,

	input  logic           in_valid,
	output logic           in_ready,
	input  mem_pkg::word_t in_data,

	output logic           out_valid,
	input  logic           out_ready,
	output mem_pkg::word_t out_data,

	output logic           busy,
	output logic           error,

	ram_port_if.master     store,
	stage_if.controller    stage
);

	localparam int WORDS        = 1 << SECTOR_BITS;
	localparam int SECTOR_COUNT = 1 << COUNT_BITS;

	localparam logic [SECTOR_BITS:0] CNT_WORDS = (SECTOR_BITS+1)'(WORDS);
	localparam logic [SECTOR_BITS:0] CNT_LAST  = (SECTOR_BITS+1)'(WORDS - 1);
	// copy phases take sector words plus two
	localparam logic [SECTOR_BITS:0] CNT_END   = (SECTOR_BITS+1)'(WORDS + 1);

	typedef enum logic [2:0] {
		S_IDLE,
		S_DECODE,
		S_FILL,
		S_COPY_OUT,
		S_COPY_IN,
		S_LOAD,
		S_SEND
	} state_t;

	state_t state;

	logic [SECTOR_BITS:0] cnt;
	logic                 out_valid_r;
	logic                 st_wren_r;

	cmd_pkg::hdr_word_t   hdr_r;
	mem_pkg::word_t       out_data_r;
	mem_pkg::word_t       st_data_r;
	logic [COUNT_BITS+SECTOR_BITS-1:0] st_addr_r;

	logic [COUNT_BITS-1:0]  sector;
	logic [SECTOR_BITS-1:0] word_off;
	logic [SECTOR_BITS-1:0] prev_off;
	logic                   op_ok;
	logic                   range_ok;
	logic                   hdr_bad;

	assign sector   = hdr_r.f.sector[COUNT_BITS-1:0];
	assign word_off = cnt[SECTOR_BITS-1:0];
	// buffer q lags the read pointer by one
	assign prev_off = word_off - 1'b1;

	assign op_ok    = (hdr_r.f.op == cmd_pkg::OP_WRITE) || (hdr_r.f.op == cmd_pkg::OP_READ);
	assign range_ok = hdr_r.f.sector < SECTOR_COUNT;
	assign hdr_bad  = !(op_ok && range_ok);

	always_ff @(posedge clock) begin
		if (reset) begin
			state       <= S_IDLE;
			cnt         <= '0;
			out_valid_r <= 1'b0;
			st_wren_r   <= 1'b0;
		end else begin
			st_wren_r <= 1'b0;
			case (state)
				S_IDLE: begin
					if (in_valid) begin
						state <= S_DECODE;
					end
				end
				S_DECODE: begin
					cnt <= '0;
					if (hdr_bad) begin
						state <= S_IDLE;
					end else if (hdr_r.f.op == cmd_pkg::OP_WRITE) begin
						state <= S_FILL;
					end else begin
						state <= S_COPY_IN;
					end
				end
				S_FILL: begin
					if (in_valid) begin
						cnt <= cnt + 1'b1;
						if (cnt == CNT_LAST) begin
							cnt   <= '0;
							state <= S_COPY_OUT;
						end
					end
				end
				S_COPY_OUT: begin
					cnt <= cnt + 1'b1;
					if (cnt != '0 && cnt <= CNT_WORDS) begin
						st_wren_r <= 1'b1;
					end
					if (cnt == CNT_END) begin
						state <= S_IDLE;
					end
				end
				S_COPY_IN: begin
					cnt <= cnt + 1'b1;
					if (cnt == CNT_END) begin
						cnt   <= '0;
						state <= S_LOAD;
					end
				end
				S_LOAD: begin
					out_valid_r <= 1'b1;
					state       <= S_SEND;
				end
				S_SEND: begin
					if (out_ready) begin
						out_valid_r <= 1'b0;
						cnt         <= cnt + 1'b1;
						state       <= (cnt == CNT_LAST) ? S_IDLE : S_LOAD;
					end
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	// payload registers
	always_ff @(posedge clock) begin
		if (state == S_IDLE && in_valid) begin
			hdr_r.raw <= in_data;
		end
		case (state)
			S_COPY_OUT: begin
				st_addr_r <= {sector, prev_off};
				st_data_r <= stage.q;
			end
			S_COPY_IN: begin
				if (cnt < CNT_WORDS) begin
					st_addr_r <= {sector, word_off};
				end
			end
			S_LOAD: begin
				out_data_r <= stage.q;
			end
			default: begin
			end
		endcase
	end

	assign store.address = st_addr_r;
	assign store.data    = st_data_r;
	assign store.wren    = st_wren_r;

	// store q arrives two cycles after the counter that addressed it
	assign stage.wr   = (state == S_FILL && in_valid) || (state == S_COPY_IN && cnt >= 2);
	assign stage.data = (state == S_FILL) ? in_data : store.q;
	// pointer steps as each output word is captured
	assign stage.rd   = (state == S_COPY_OUT && cnt < CNT_WORDS) || (state == S_LOAD);

	assign in_ready  = (state == S_IDLE) || (state == S_FILL);
	assign error     = (state == S_DECODE) && hdr_bad;
	assign busy      = (state != S_IDLE);
	assign out_valid = out_valid_r;
	assign out_data  = out_data_r;

	// a stalled word holds until the sink takes it
	assert property (@(posedge clock) disable iff (reset)
		(out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
		else $error("sector_ctrl: output changed under back-pressure");

endmodule

// ==== rtl/stage_buffer.sv ====
`timescale 1ns/1ns

module stage_buffer #(
	parameter int SECTOR_BITS = 4
) (
	input logic     clock,
	input logic     reset,
	stage_if.buffer stage
);

	localparam int WORDS = 1 << SECTOR_BITS;

	mem_pkg::word_t buf_mem [0:WORDS-1];
	mem_pkg::word_t q_r;

	logic [SECTOR_BITS-1:0] wr_ptr;
	logic [SECTOR_BITS-1:0] rd_ptr;

	// each side restarts the other from word zero
	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else if (stage.wr) begin
			wr_ptr <= wr_ptr + 1'b1;
			rd_ptr <= '0;
		end else if (stage.rd) begin
			rd_ptr <= rd_ptr + 1'b1;
			wr_ptr <= '0;
		end
	end

	always_ff @(posedge clock) begin
		if (stage.wr) begin
			buf_mem[wr_ptr] <= stage.data;
		end
	end

	// registered read address, q trails the pointer by a cycle
	always_ff @(posedge clock) begin
		q_r <= buf_mem[rd_ptr];
	end

	assign stage.q = q_r;

	// controller keeps fill and drain phases apart
	assert property (@(posedge clock) disable iff (reset)
		!(stage.wr && stage.rd))
		else $error("stage_buffer: wr and rd high together");

endmodule

// ==== rtl/store_ram.sv ====
`timescale 1ns/1ns

module store_ram #(
	parameter int ADDR_WIDTH = 7
) (
	input logic        clock,
	ram_port_if.memory port_a,
	ram_port_if.memory port_b
);

	localparam int DEPTH = 1 << ADDR_WIDTH;

	mem_pkg::word_t mem [0:DEPTH-1];
	mem_pkg::word_t q_a;
	mem_pkg::word_t q_b;

	// both ports share one array, each with its own address register
	always_ff @(posedge clock) begin
		if (port_a.wren) begin
			mem[port_a.address] <= port_a.data;
			// new data on a write to the same port
			q_a <= port_a.data;
		end else begin
			q_a <= mem[port_a.address];
		end

		if (port_b.wren) begin
			mem[port_b.address] <= port_b.data;
			q_b <= port_b.data;
		end else begin
			q_b <= mem[port_b.address];
		end
	end

	assign port_a.q = q_a;
	assign port_b.q = q_b;

	// host and core never target the same word in one write cycle
	assert property (@(posedge clock)
		!(port_a.wren && port_b.wren && (port_a.address == port_b.address)))
		else $error("store_ram: both ports write address %0h", port_a.address);

endmodule

// ==== rtl/stage_if.sv ====
`timescale 1ns/1ns

interface stage_if;

	// write at write pointer, restarts reading
	logic           wr;
	mem_pkg::word_t data;
	// step read pointer, restarts writing
	logic           rd;
	mem_pkg::word_t q;

	modport controller (
		output wr,
		output data,
		output rd,
		input  q
	);

	modport buffer (
		input  wr,
		input  data,
		input  rd,
		output q
	);

endinterface

// ==== rtl/ram_port_if.sv ====
`timescale 1ns/1ns

interface ram_port_if #(
	parameter int ADDR_WIDTH = 7
);

	logic [ADDR_WIDTH-1:0] address;
	mem_pkg::word_t        data;
	logic                  wren;
	// word at the address of the previous cycle
	mem_pkg::word_t        q;

	modport master (
		output address,
		output data,
		output wren,
		input  q
	);

	modport memory (
		input  address,
		input  data,
		input  wren,
		output q
	);

endinterface

// ==== rtl/cmd_pkg.sv ====
package cmd_pkg;

	// opcode in the top two bits of a header word
	typedef enum logic [1:0] {
		OP_NONE  = 2'd0,
		OP_WRITE = 2'd1,
		OP_READ  = 2'd2,
		OP_RSVD  = 2'd3
	} op_t;

	// field layout of a header word, msb first
	typedef struct packed {
		op_t        op;
		logic [5:0] rsvd;
		logic [7:0] sector;
	} hdr_fields_t;

	// header seen either as a plain stream word or through its fields
	typedef union packed {
		mem_pkg::word_t raw;
		hdr_fields_t    f;
	} hdr_word_t;

endpackage

// ==== rtl/mem_pkg.sv ====
package mem_pkg;

	// width of every data path in the bridge
	localparam int WORD_WIDTH = 16;

	// one word as seen by the host streams, the staging buffer and the store
	typedef logic [WORD_WIDTH-1:0] word_t;

endpackage
